/* rtl/divsqrt_cfg.svh */
`ifndef DIVSQRT_CFG_SVH
`define DIVSQRT_CFG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
// Operand and result width, even so the root has half of it
`define DS_WIDTH 16
// Operation tag carried alongside each result
`define DS_TAG_WIDTH 4
// Divide-by-zero and inexact flags
`define DS_STATUS_WIDTH 2

// ----------------------------------------
// Pipeline depths
// ----------------------------------------
// Register stages in front of the control FSM
`define DS_NUM_INP_REGS 1
// Register stages behind the control FSM
`define DS_NUM_OUT_REGS 1

`endif

/* rtl/divsqrt_pkg.sv */
package divsqrt_pkg;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  // Unsigned quotient or floor square root
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // ----------------------------------------
  // Control FSM states
  // ----------------------------------------
  // IDLE waits for work, BUSY runs the unit, HOLD keeps a stalled result
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_BUSY = 2'd1,
    ST_HOLD = 2'd2
  } divsqrt_state_e;

  // Status vector bit positions
  // Divide by zero
  localparam int unsigned STATUS_DZ = 0;
  // Inexact, nonzero remainder or residual
  localparam int unsigned STATUS_NX = 1;

endpackage

/* rtl/divsqrt_pipe_regs.sv */
`timescale 1ns/1ps

module divsqrt_pipe_regs #(
  parameter int unsigned NumRegs = 1,
  parameter int unsigned Width   = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] out_data_o,
  output logic             busy_o
);

  // Index i holds the signal after i register stages
  logic [Width-1:0] stage_data  [0:NumRegs];
  logic             stage_valid [0:NumRegs];
  // Ready is combinational through all stages
  logic             stage_ready [0:NumRegs];

  // Stage 0 is the module input
  assign stage_data[0]  = in_data_i;
  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    // Valid bit, cleared by reset and flush
    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload only loads on a real item
    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Last stage faces downstream
  assign stage_ready[NumRegs] = out_ready_i;
  assign out_valid_o          = stage_valid[NumRegs];
  assign out_data_o           = stage_data[NumRegs];

  // Any valid register stage counts as in flight
  // Zero stages leave busy low
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumRegs; i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

endmodule

/* rtl/divsqrt_iter_unit.sv */
`timescale 1ns/1ps
`include "divsqrt_cfg.svh"

module divsqrt_iter_unit (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        kill_i,
  input  logic                        start_div_i,
  input  logic                        start_sqrt_i,
  input  logic [`DS_WIDTH-1:0]        op_a_i,
  input  logic [`DS_WIDTH-1:0]        op_b_i,
  output logic                        unit_ready_o,
  output logic                        done_o,
  output logic [`DS_WIDTH-1:0]        result_o,
  output logic [`DS_STATUS_WIDTH-1:0] status_o
);

  localparam int unsigned W     = `DS_WIDTH;
  localparam int unsigned HalfW = `DS_WIDTH / 2;
  // Sqrt trial width, residual plus two radicand bits plus one
  localparam int unsigned SqW   = HalfW + 3;
  localparam int unsigned CntW  = $clog2(`DS_WIDTH);

  // Control state
  logic                      running_q;
  logic                      done_q;
  logic [CntW-1:0]           cnt_q;
  divsqrt_pkg::divsqrt_op_e  mode_q;

  // Datapath registers
  // Dividend shifting into quotient, or radicand shifting out
  logic [W-1:0]     acc_q;
  // Partial remainder or sqrt residual
  logic [W-1:0]     rem_q;
  logic [W-1:0]     dvs_q;
  logic [HalfW-1:0] root_q;

  // Start only when idle and not killed
  logic start;
  logic step_en;
  assign start   = (start_div_i | start_sqrt_i) & ~running_q & ~kill_i;
  assign step_en = (start | running_q) & ~kill_i;

  // ----------------------------------------
  // One iteration step
  // ----------------------------------------
  // First step runs in the start cycle straight from the operands
  divsqrt_pkg::divsqrt_op_e cur_mode;
  logic [W-1:0]     cur_acc;
  logic [W-1:0]     cur_rem;
  logic [W-1:0]     cur_dvs;
  logic [HalfW-1:0] cur_root;
  logic [W:0]       dv_trial;
  logic             dv_ge;
  logic [SqW-1:0]   sq_trial;
  logic [SqW-1:0]   sq_sub;
  logic             sq_ge;
  logic [SqW-1:0]   sq_res;
  logic [W-1:0]     acc_d;
  logic [W-1:0]     rem_d;
  logic [HalfW-1:0] root_d;

  always_comb begin
    cur_mode = start ? (start_div_i ? divsqrt_pkg::OP_DIV : divsqrt_pkg::OP_SQRT) : mode_q;
    cur_acc  = start ? op_a_i : acc_q;
    cur_rem  = start ? '0 : rem_q;
    cur_dvs  = start ? op_b_i : dvs_q;
    cur_root = start ? '0 : root_q;

    // Division, shift in next dividend bit and try subtracting
    dv_trial = {cur_rem, cur_acc[W-1]};
    dv_ge    = dv_trial >= {1'b0, cur_dvs};

    // Square root, bring down two bits and try 4*root+1
    sq_trial = {cur_rem[HalfW:0], cur_acc[W-1:W-2]};
    sq_sub   = {1'b0, cur_root, 2'b01};
    sq_ge    = sq_trial >= sq_sub;
    sq_res   = sq_ge ? (sq_trial - sq_sub) : sq_trial;

    if (cur_mode == divsqrt_pkg::OP_DIV) begin
      acc_d  = {cur_acc[W-2:0], dv_ge};
      // Difference is below the divisor so W bits suffice
      rem_d  = dv_ge ? (dv_trial[W-1:0] - cur_dvs) : dv_trial[W-1:0];
      root_d = cur_root;
    end else begin
      acc_d  = {cur_acc[W-3:0], 2'b00};
      rem_d  = {{(W-SqW){1'b0}}, sq_res};
      root_d = {cur_root[HalfW-2:0], sq_ge};
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (step_en) begin
      acc_q  <= acc_d;
      rem_q  <= rem_d;
      root_q <= root_d;
    end
    // Divisor stays for the whole run, needed for the DZ flag
    if (start) begin
      dvs_q <= op_b_i;
    end
  end

  // Iteration counter holds the steps left after the current one
  always_ff @(posedge clk_i) begin
    if (rst_i || kill_i) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
      mode_q    <= divsqrt_pkg::OP_DIV;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        running_q <= 1'b1;
        mode_q    <= cur_mode;
        cnt_q     <= start_div_i ? CntW'(W - 1) : CntW'(HalfW - 1);
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
        // Last step lands this edge, result shows next cycle
        if (cnt_q == CntW'(1)) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  assign unit_ready_o = ~running_q;
  assign done_o       = done_q;

  // Result and flags, meaningful with done
  always_comb begin
    status_o = '0;
    if (mode_q == divsqrt_pkg::OP_DIV) begin
      // Zero divisor already yields an all-ones quotient
      result_o                       = acc_q;
      status_o[divsqrt_pkg::STATUS_DZ] = (dvs_q == '0);
      status_o[divsqrt_pkg::STATUS_NX] = (dvs_q != '0) && (rem_q != '0);
    end else begin
      result_o                       = {{(W-HalfW){1'b0}}, root_q};
      status_o[divsqrt_pkg::STATUS_NX] = (rem_q != '0);
    end
  end

endmodule

/* rtl/divsqrt_ctrl.sv */
`timescale 1ns/1ps
`include "divsqrt_cfg.svh"

module divsqrt_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flush_i,
  // Operation from the input pipeline
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  divsqrt_pkg::divsqrt_op_e    op_i,
  input  logic [`DS_WIDTH-1:0]        op_a_i,
  input  logic [`DS_WIDTH-1:0]        op_b_i,
  input  logic [`DS_TAG_WIDTH-1:0]    tag_i,
  // Iterative unit
  output logic                        start_div_o,
  output logic                        start_sqrt_o,
  output logic [`DS_WIDTH-1:0]        unit_op_a_o,
  output logic [`DS_WIDTH-1:0]        unit_op_b_o,
  input  logic                        unit_ready_i,
  input  logic                        unit_done_i,
  input  logic [`DS_WIDTH-1:0]        unit_result_i,
  input  logic [`DS_STATUS_WIDTH-1:0] unit_status_i,
  // Result toward the output pipeline
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [`DS_WIDTH-1:0]        result_o,
  output logic [`DS_STATUS_WIDTH-1:0] status_o,
  output logic [`DS_TAG_WIDTH-1:0]    tag_o,
  output logic                        busy_o
);

  divsqrt_pkg::divsqrt_state_e state_q;
  divsqrt_pkg::divsqrt_state_e state_d;

  // FSM side of the input handshake, unit readiness added below
  logic fsm_ready;
  logic op_start;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_comb begin
    fsm_ready   = 1'b0;
    out_valid_o = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      divsqrt_pkg::ST_IDLE: begin
        fsm_ready = 1'b1;
        if (in_valid_i && unit_ready_i) begin
          state_d = divsqrt_pkg::ST_BUSY;
        end
      end
      divsqrt_pkg::ST_BUSY: begin
        if (unit_done_i) begin
          // Offer the result directly
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            fsm_ready = 1'b1;
            state_d   = divsqrt_pkg::ST_IDLE;
            // Back to back with the next operation
            if (in_valid_i && unit_ready_i) begin
              state_d = divsqrt_pkg::ST_BUSY;
            end
          end else begin
            state_d = divsqrt_pkg::ST_HOLD;
          end
        end
      end
      divsqrt_pkg::ST_HOLD: begin
        // Stalled result waits in the hold register
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          fsm_ready = 1'b1;
          state_d   = divsqrt_pkg::ST_IDLE;
          if (in_valid_i && unit_ready_i) begin
            state_d = divsqrt_pkg::ST_BUSY;
          end
        end
      end
      default: state_d = divsqrt_pkg::ST_IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      fsm_ready   = 1'b0;
      out_valid_o = 1'b0;
      state_d     = divsqrt_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= divsqrt_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Take an operation only when the unit can start it
  assign in_ready_o   = fsm_ready & unit_ready_i;
  assign op_start     = in_valid_i & in_ready_o;
  assign start_div_o  = op_start & (op_i == divsqrt_pkg::OP_DIV);
  assign start_sqrt_o = op_start & (op_i == divsqrt_pkg::OP_SQRT);
  assign unit_op_a_o  = op_a_i;
  assign unit_op_b_o  = op_b_i;

  // ----------------------------------------
  // Tag and hold registers
  // ----------------------------------------
  logic [`DS_TAG_WIDTH-1:0]    tag_q;
  logic [`DS_WIDTH-1:0]        held_result_q;
  logic [`DS_STATUS_WIDTH-1:0] held_status_q;
  logic                        hold_en;

  // Tag follows its operation from start to result
  always_ff @(posedge clk_i) begin
    if (op_start) begin
      tag_q <= tag_i;
    end
  end

  // Capture a finished result that downstream refused
  assign hold_en = unit_done_i & ~out_ready_i & ~flush_i & (state_q == divsqrt_pkg::ST_BUSY);

  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= unit_result_i;
      held_status_q <= unit_status_i;
    end
  end

  // Output select, hold register first
  assign result_o = (state_q == divsqrt_pkg::ST_HOLD) ? held_result_q : unit_result_i;
  assign status_o = (state_q == divsqrt_pkg::ST_HOLD) ? held_status_q : unit_status_i;
  assign tag_o    = tag_q;

  // Work in flight inside the FSM
  assign busy_o = (state_q != divsqrt_pkg::ST_IDLE);

endmodule

/* rtl/divsqrt_top.sv */
`timescale 1ns/1ps
`include "divsqrt_cfg.svh"

module divsqrt_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        flush_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  divsqrt_pkg::divsqrt_op_e    op_i,
  input  logic [`DS_WIDTH-1:0]        op_a_i,
  input  logic [`DS_WIDTH-1:0]        op_b_i,
  input  logic [`DS_TAG_WIDTH-1:0]    tag_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [`DS_WIDTH-1:0]        result_o,
  output logic [`DS_STATUS_WIDTH-1:0] status_o,
  output logic [`DS_TAG_WIDTH-1:0]    tag_o,
  output logic                        busy_o
);

  // Opcode, operand a, operand b, tag
  localparam int unsigned InpW = 1 + 2 * `DS_WIDTH + `DS_TAG_WIDTH;
  // Result, status, tag
  localparam int unsigned OutW = `DS_WIDTH + `DS_STATUS_WIDTH + `DS_TAG_WIDTH;

  // ----------------------------------------
  // Input pipeline
  // ----------------------------------------
  logic [InpW-1:0] inp_data;
  logic            inp_valid;
  logic            inp_ready;
  logic            inp_busy;

  divsqrt_pipe_regs #(
    .NumRegs ( `DS_NUM_INP_REGS ),
    .Width   ( InpW             )
  ) u_inp_pipe (
    .clk_i       ( clk_i                             ),
    .rst_i       ( rst_i                             ),
    .flush_i     ( flush_i                           ),
    .in_valid_i  ( in_valid_i                        ),
    .in_ready_o  ( in_ready_o                        ),
    .in_data_i   ( {op_i, op_a_i, op_b_i, tag_i}     ),
    .out_valid_o ( inp_valid                         ),
    .out_ready_i ( inp_ready                         ),
    .out_data_o  ( inp_data                          ),
    .busy_o      ( inp_busy                          )
  );

  // Unpack fields for the control block
  divsqrt_pkg::divsqrt_op_e    inp_op;
  logic [`DS_WIDTH-1:0]        inp_op_a;
  logic [`DS_WIDTH-1:0]        inp_op_b;
  logic [`DS_TAG_WIDTH-1:0]    inp_tag;

  assign inp_op   = divsqrt_pkg::divsqrt_op_e'(inp_data[InpW-1]);
  assign inp_op_a = inp_data[InpW-2 -: `DS_WIDTH];
  assign inp_op_b = inp_data[`DS_TAG_WIDTH +: `DS_WIDTH];
  assign inp_tag  = inp_data[`DS_TAG_WIDTH-1:0];

  // ----------------------------------------
  // Control and iterative unit
  // ----------------------------------------
  logic                        start_div;
  logic                        start_sqrt;
  logic [`DS_WIDTH-1:0]        unit_op_a;
  logic [`DS_WIDTH-1:0]        unit_op_b;
  logic                        unit_ready;
  logic                        unit_done;
  logic [`DS_WIDTH-1:0]        unit_result;
  logic [`DS_STATUS_WIDTH-1:0] unit_status;
  logic                        res_valid;
  logic                        res_ready;
  logic [`DS_WIDTH-1:0]        res_result;
  logic [`DS_STATUS_WIDTH-1:0] res_status;
  logic [`DS_TAG_WIDTH-1:0]    res_tag;
  logic                        ctrl_busy;

  divsqrt_ctrl u_ctrl (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .flush_i       ( flush_i     ),
    .in_valid_i    ( inp_valid   ),
    .in_ready_o    ( inp_ready   ),
    .op_i          ( inp_op      ),
    .op_a_i        ( inp_op_a    ),
    .op_b_i        ( inp_op_b    ),
    .tag_i         ( inp_tag     ),
    .start_div_o   ( start_div   ),
    .start_sqrt_o  ( start_sqrt  ),
    .unit_op_a_o   ( unit_op_a   ),
    .unit_op_b_o   ( unit_op_b   ),
    .unit_ready_i  ( unit_ready  ),
    .unit_done_i   ( unit_done   ),
    .unit_result_i ( unit_result ),
    .unit_status_i ( unit_status ),
    .out_valid_o   ( res_valid   ),
    .out_ready_i   ( res_ready   ),
    .result_o      ( res_result  ),
    .status_o      ( res_status  ),
    .tag_o         ( res_tag     ),
    .busy_o        ( ctrl_busy   )
  );

  // Flush also kills the running iteration
  divsqrt_iter_unit u_unit (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .kill_i       ( flush_i     ),
    .start_div_i  ( start_div   ),
    .start_sqrt_i ( start_sqrt  ),
    .op_a_i       ( unit_op_a   ),
    .op_b_i       ( unit_op_b   ),
    .unit_ready_o ( unit_ready  ),
    .done_o       ( unit_done   ),
    .result_o     ( unit_result ),
    .status_o     ( unit_status )
  );

  // ----------------------------------------
  // Output pipeline
  // ----------------------------------------
  logic [OutW-1:0] out_data;
  logic            out_busy;

  divsqrt_pipe_regs #(
    .NumRegs ( `DS_NUM_OUT_REGS ),
    .Width   ( OutW             )
  ) u_out_pipe (
    .clk_i       ( clk_i                              ),
    .rst_i       ( rst_i                              ),
    .flush_i     ( flush_i                            ),
    .in_valid_i  ( res_valid                          ),
    .in_ready_o  ( res_ready                          ),
    .in_data_i   ( {res_result, res_status, res_tag}  ),
    .out_valid_o ( out_valid_o                        ),
    .out_ready_i ( out_ready_i                        ),
    .out_data_o  ( out_data                           ),
    .busy_o      ( out_busy                           )
  );

  assign {result_o, status_o, tag_o} = out_data;

  // Anything valid anywhere keeps the unit busy
  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

/* verif/tb_divsqrt.sv */
`timescale 1ns/1ps
`include "divsqrt_cfg.svh"

module tb_divsqrt;

  localparam int unsigned W       = `DS_WIDTH;
  localparam int unsigned TagW    = `DS_TAG_WIDTH;
  localparam int unsigned StW     = `DS_STATUS_WIDTH;
  // Longest any single wait may take, in cycles
  localparam int unsigned Timeout = 2000;
  // Phase ids, recorded per operation for failure lines
  localparam int PhReset = 0;
  localparam int PhDiv   = 1;
  localparam int PhSqrt  = 2;
  localparam int PhDz    = 3;
  localparam int PhBp    = 4;
  localparam int PhFlush = 5;

  // DUT inputs
  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     flush_i;
  logic                     in_valid_i;
  divsqrt_pkg::divsqrt_op_e op_i;
  logic [W-1:0]             op_a_i;
  logic [W-1:0]             op_b_i;
  logic [TagW-1:0]          tag_i;
  // Only driven by the back-pressure process below
  logic                     out_ready_i = 1'b1;
  // DUT outputs
  logic                     in_ready_o;
  logic                     out_valid_o;
  logic [W-1:0]             result_o;
  logic [StW-1:0]           status_o;
  logic [TagW-1:0]          tag_o;
  logic                     busy_o;

  // Stimulus control
  logic                     bp_en;
  int                       cur_phase;
  logic [TagW-1:0]          next_tag;

  // Scoreboard, one entry per accepted operation in accept order
  logic [W-1:0]             exp_result_q[$];
  logic [StW-1:0]           exp_status_q[$];
  logic [TagW-1:0]          exp_tag_q[$];
  int                       exp_phase_q[$];
  logic                     head_valid;
  logic [W-1:0]             head_result;
  logic [StW-1:0]           head_status;
  logic [TagW-1:0]          head_tag;
  int                       head_phase;
  int unsigned              sb_count;
  logic [(1<<TagW)-1:0]     flushed_tags;

  // Last-cycle copies for the reset and stability checks
  logic                     rst_prev = 1'b1;
  logic                     hold_prev;
  logic [W-1:0]             prev_result;
  logic [StW-1:0]           prev_status;
  logic [TagW-1:0]          prev_tag;

  always #10 clk_i = ~clk_i;

  divsqrt_top u_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .op_i        ( op_i        ),
    .op_a_i      ( op_a_i      ),
    .op_b_i      ( op_b_i      ),
    .tag_i       ( tag_i       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int unsigned ref_isqrt(input logic [W-1:0] a);
    int unsigned r;
    r = 0;
    // Largest r whose square fits
    while ((r + 1) * (r + 1) <= a) begin
      r++;
    end
    return r;
  endfunction

  function automatic logic [W-1:0] ref_result(input divsqrt_pkg::divsqrt_op_e op,
                                              input logic [W-1:0] a, input logic [W-1:0] b);
    if (op == divsqrt_pkg::OP_SQRT) begin
      return W'(ref_isqrt(a));
    end else if (b == '0) begin
      return '1;
    end else begin
      return a / b;
    end
  endfunction

  function automatic logic [StW-1:0] ref_status(input divsqrt_pkg::divsqrt_op_e op,
                                                input logic [W-1:0] a, input logic [W-1:0] b);
    logic [StW-1:0] st;
    int unsigned    r;
    st = '0;
    if (op == divsqrt_pkg::OP_SQRT) begin
      r = ref_isqrt(a);
      st[divsqrt_pkg::STATUS_NX] = ((r * r) != a);
    end else if (b == '0) begin
      st[divsqrt_pkg::STATUS_DZ] = 1'b1;
    end else begin
      st[divsqrt_pkg::STATUS_NX] = ((a % b) != '0);
    end
    return st;
  endfunction

  function automatic string phase_name(input int ph);
    case (ph)
      PhReset: return "reset";
      PhDiv:   return "division";
      PhSqrt:  return "square_root";
      PhDz:    return "divide_by_zero";
      PhBp:    return "back_pressure";
      default: return "flush";
    endcase
  endfunction

  // Next tag that was never flushed
  function automatic logic [TagW-1:0] pick_tag(input logic [TagW-1:0] start);
    logic [TagW-1:0] t;
    t = start;
    for (int i = 0; i < (1 << TagW); i++) begin
      if (flushed_tags[t]) begin
        t = t + 1'b1;
      end
    end
    return t;
  endfunction

  // ----------------------------------------
  // Scoreboard update, sampled like a flop
  // ----------------------------------------
  always @(posedge clk_i) begin : scoreboard_update
    logic [(1<<TagW)-1:0] mask_d;
    mask_d = flushed_tags;
    if (rst_i) begin
      exp_result_q.delete();
      exp_status_q.delete();
      exp_tag_q.delete();
      exp_phase_q.delete();
      mask_d = '0;
    end else begin
      // Result leaves first, even in a flush cycle
      if (out_valid_o && out_ready_i && exp_tag_q.size() > 0) begin
        void'(exp_result_q.pop_front());
        void'(exp_status_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(exp_phase_q.pop_front());
      end
      if (flush_i) begin
        // Everything still in flight is gone
        foreach (exp_tag_q[i]) begin
          mask_d[exp_tag_q[i]] = 1'b1;
        end
        if (in_valid_i && in_ready_o) begin
          mask_d[tag_i] = 1'b1;
        end
        exp_result_q.delete();
        exp_status_q.delete();
        exp_tag_q.delete();
        exp_phase_q.delete();
      end else if (in_valid_i && in_ready_o) begin
        exp_result_q.push_back(ref_result(op_i, op_a_i, op_b_i));
        exp_status_q.push_back(ref_status(op_i, op_a_i, op_b_i));
        exp_tag_q.push_back(tag_i);
        exp_phase_q.push_back(cur_phase);
      end
    end
    flushed_tags <= mask_d;
    sb_count     <= exp_tag_q.size();
    head_valid   <= (exp_tag_q.size() > 0);
    if (exp_tag_q.size() > 0) begin
      head_result <= exp_result_q[0];
      head_status <= exp_status_q[0];
      head_tag    <= exp_tag_q[0];
      head_phase  <= exp_phase_q[0];
    end
  end

  always @(posedge clk_i) begin
    rst_prev    <= rst_i;
    hold_prev   <= !rst_i && out_valid_o && !out_ready_i && !flush_i;
    prev_result <= result_o;
    prev_status <= status_o;
    prev_tag    <= tag_o;
  end

  // Random back-pressure, half the cycles stalled
  always @(posedge clk_i) begin
    if (bp_en) begin
      out_ready_i <= ($urandom_range(1, 0) == 1);
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // First cycle out of reset
  a_reset: assert property (@(posedge clk_i)
      (rst_prev && !rst_i) |-> (!out_valid_o && !busy_o && in_ready_o))
    else begin
      $display("[FAIL] %s: expected valid=0 busy=0 ready=1, actual valid=%0b busy=%0b ready=%0b",
               phase_name(PhReset), $sampled(out_valid_o), $sampled(busy_o),
               $sampled(in_ready_o));
      $display("Simulation FAILED");
      $fatal(1, "reset state check");
    end

  // No result without a matching accepted operation
  a_spurious: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_o && out_ready_i) |-> head_valid)
    else begin
      $display("Result with tag %0h arrived with no operation outstanding", $sampled(tag_o));
      $display("Simulation FAILED");
      $fatal(1, "unexpected result");
    end

  a_result: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_o && out_ready_i && head_valid) |-> (result_o == head_result))
    else begin
      $display("[FAIL] %s result: expected %h, actual %h", phase_name($sampled(head_phase)),
               $sampled(head_result), $sampled(result_o));
      $display("Simulation FAILED");
      $fatal(1, "result mismatch");
    end

  a_status: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_o && out_ready_i && head_valid) |-> (status_o == head_status))
    else begin
      $display("[FAIL] %s status: expected %b, actual %b", phase_name($sampled(head_phase)),
               $sampled(head_status), $sampled(status_o));
      $display("Simulation FAILED");
      $fatal(1, "status mismatch");
    end

  // Tag order doubles as the accept-order check
  a_tag: assert property (@(posedge clk_i) disable iff (rst_i)
      (out_valid_o && out_ready_i && head_valid) |-> (tag_o == head_tag))
    else begin
      $display("[FAIL] %s tag: expected %h, actual %h", phase_name($sampled(head_phase)),
               $sampled(head_tag), $sampled(tag_o));
      $display("Simulation FAILED");
      $fatal(1, "tag mismatch");
    end

  a_flushed: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o |-> !flushed_tags[tag_o])
    else begin
      $display("[FAIL] %s tag: expected none of %b, actual %h", phase_name(PhFlush),
               $sampled(flushed_tags), $sampled(tag_o));
      $display("Simulation FAILED");
      $fatal(1, "flushed result seen");
    end

  // Stalled output keeps valid and data
  a_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      hold_prev |-> (out_valid_o && result_o == prev_result && status_o == prev_status &&
                     tag_o == prev_tag))
    else begin
      $display("[FAIL] %s stall: expected valid=1 %h/%b/%h, actual valid=%0b %h/%b/%h",
               phase_name(PhBp), $sampled(prev_result), $sampled(prev_status),
               $sampled(prev_tag), $sampled(out_valid_o), $sampled(result_o),
               $sampled(status_o), $sampled(tag_o));
      $display("Simulation FAILED");
      $fatal(1, "output changed under stall");
    end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1, "wait timed out");
  endtask

  // Called and returns on a rising edge
  task automatic issue_op(input divsqrt_pkg::divsqrt_op_e op, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    int unsigned cnt;
    logic        taken;
    cnt        = 0;
    taken      = 1'b0;
    next_tag   = pick_tag(next_tag);
    in_valid_i <= 1'b1;
    op_i       <= op;
    op_a_i     <= a;
    op_b_i     <= b;
    tag_i      <= next_tag;
    while (!taken) begin
      // Ready is settled by mid cycle
      @(negedge clk_i);
      taken = in_ready_o;
      @(posedge clk_i);
      cnt++;
      if (!taken && cnt >= Timeout) begin
        report_timeout("the input handshake");
      end
    end
    in_valid_i <= 1'b0;
    next_tag   = next_tag + 1'b1;
  endtask

  task automatic wait_drained();
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (sb_count != 0) begin
      @(negedge clk_i);
      cnt++;
      if (cnt >= Timeout) begin
        report_timeout("all outstanding results");
      end
    end
    @(posedge clk_i);
  endtask

  task automatic wait_not_busy();
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (busy_o) begin
      @(negedge clk_i);
      cnt++;
      if (cnt >= Timeout) begin
        report_timeout("busy_o to fall");
      end
    end
    @(posedge clk_i);
  endtask

  task automatic wait_unit_running();
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (u_dut.unit_ready) begin
      @(negedge clk_i);
      cnt++;
      if (cnt >= Timeout) begin
        report_timeout("the iterative unit to start");
      end
    end
    @(posedge clk_i);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : stimulus
    int unsigned     seed_val;
    logic [W-1:0]    a;
    logic [W-1:0]    b;
    int unsigned     r;
    seed_val   = $urandom(74323);
    rst_i      = 1'b1;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    op_i       = divsqrt_pkg::OP_DIV;
    op_a_i     = '0;
    op_b_i     = '0;
    tag_i      = '0;
    bp_en      = 1'b0;
    cur_phase  = PhReset;
    next_tag   = '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    // Reset state is checked on this edge
    @(posedge clk_i);

    // Division, small and wide divisors
    cur_phase <= PhDiv;
    for (int i = 0; i < 24; i++) begin
      a = W'($urandom());
      b = (i % 2 == 0) ? W'($urandom_range(255, 1)) : W'($urandom_range(16'hFFFF, 1));
      issue_op(divsqrt_pkg::OP_DIV, a, b);
    end
    issue_op(divsqrt_pkg::OP_DIV, 16'd1000, 16'd10);
    wait_drained();

    // Square root, every other radicand a perfect square
    cur_phase <= PhSqrt;
    issue_op(divsqrt_pkg::OP_SQRT, 16'd0, 16'd0);
    issue_op(divsqrt_pkg::OP_SQRT, 16'hFFFF, 16'd0);
    for (int i = 0; i < 24; i++) begin
      r = $urandom_range(255, 0);
      a = (i % 2 == 0) ? W'(r * r) : W'($urandom());
      issue_op(divsqrt_pkg::OP_SQRT, a, 16'd0);
    end
    wait_drained();

    // Divide by zero
    cur_phase <= PhDz;
    issue_op(divsqrt_pkg::OP_DIV, 16'd0, 16'd0);
    for (int i = 0; i < 4; i++) begin
      issue_op(divsqrt_pkg::OP_DIV, W'($urandom()), 16'd0);
    end
    wait_drained();

    // Back-pressure with mixed operations
    cur_phase <= PhBp;
    bp_en     <= 1'b1;
    for (int i = 0; i < 32; i++) begin
      a = W'($urandom());
      b = W'($urandom_range(4, 0));
      if ($urandom_range(1, 0) == 1) begin
        issue_op(divsqrt_pkg::OP_SQRT, a, b);
      end else begin
        issue_op(divsqrt_pkg::OP_DIV, a, b);
      end
    end
    wait_drained();
    bp_en <= 1'b0;

    // Flush one running operation and one queued behind it
    cur_phase <= PhFlush;
    issue_op(divsqrt_pkg::OP_DIV, 16'd54321, 16'd7);
    issue_op(divsqrt_pkg::OP_SQRT, 16'd40000, 16'd0);
    wait_unit_running();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_not_busy();
    issue_op(divsqrt_pkg::OP_DIV, 16'd50000, 16'd123);
    wait_drained();
    wait_not_busy();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/divsqrt_pkg.sv
rtl/divsqrt_pipe_regs.sv
rtl/divsqrt_iter_unit.sv
rtl/divsqrt_ctrl.sv
rtl/divsqrt_top.sv
verif/tb_divsqrt.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench; exit status is the simulation result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_divsqrt -f compile.f -Mdir obj_dir -o tb_divsqrt &&
  ./obj_dir/tb_divsqrt ||
  exit 1
